//--- verilog.f
+incdir+dv
source/exu_pkg.sv
source/exu_alu.sv
source/exu_bru.sv
source/exu_lsu.sv
source/exu_regfile.sv
source/exu_ecl.sv
source/cpu7_exu.sv
dv/tb_cpu7_exu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
   --top-module tb_cpu7_exu -f verilog.f -o vsim_exu
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/vsim_exu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1

//--- dv/exu_ref_model.svh
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// expected register file and memory, plus the memory seen by the responder
logic [31:0] reg_exp [32];
logic [31:0] mem_exp [64];
logic [31:0] mem [64];

function automatic logic [31:0] fill_word(input int idx);
   return (idx * 32'h01010101) ^ 32'hc3a50000 ^ (idx << 20);
endfunction

function automatic logic [31:0] ref_alu(input logic [3:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
   case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_NOR:  return ~(a | b);
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $signed(a) >>> b[4:0];
      default:  return b;
   endcase
endfunction

function automatic logic ref_taken(input logic [3:0] op, input logic [31:0] a,
                                   input logic [31:0] b);
   case (op)
      BRU_BEQ:  return a == b;
      BRU_BNE:  return a != b;
      BRU_BLT:  return $signed(a) < $signed(b);
      BRU_BGE:  return $signed(a) >= $signed(b);
      BRU_BLTU: return a < b;
      BRU_BGEU: return a >= b;
      default:  return 1'b1;
   endcase
endfunction

// pick the byte, then sign or zero extend
function automatic logic [31:0] ref_load(input logic [2:0] op, input logic [31:0] word,
                                         input logic [1:0] lo);
   logic [7:0] b;
   b = word[lo*8 +: 8];
   if (op == LSU_LDW) begin
      return word;
   end else if (op == LSU_LDB) begin
      return {{24{b[7]}}, b};
   end
   return {24'd0, b};
endfunction

`endif

//--- dv/tb_cpu7_exu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu7_exu import exu_pkg::*; ();

   localparam int CYCLE_LIMIT = 8000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        ifu_exu_valid_e, alu_valid, bru_valid, lsu_valid;
   logic [31:0] alu_a, alu_b, pc, bru_offset, imm;
   logic [3:0]  alu_op, bru_op;
   logic [2:0]  lsu_op;
   logic [4:0]  rf_target, rs1, rs2;
   logic        wen;
   logic [31:0] rs1_data, rs2_data;
   logic        stall_req, br_taken;
   logic [31:0] brpc;
   logic        data_req, data_wr, data_addr_ok, data_data_ok_m;
   logic [31:0] data_addr, data_wdata, data_rdata_m;
   logic [3:0]  data_wstrb;

   int          err_count = 0;
   int          check_count = 0;
   int          cycle_count = 0;
   int          lsu_count = 0;
   int          req_count = 0;
   logic        stall_seen = 1'b0;
   logic        load_pend;
   logic [1:0]  data_cnt, addr_wait;
   logic [31:0] load_addr;
   logic [31:0] exp_addr, exp_wdata;
   logic [3:0]  exp_wstrb;
   logic        exp_store;
   logic        exp_stall;

   `include "exu_ref_model.svh"

   cpu7_exu dut_i (
      .clk(clk), .rst_n(rst_n),
      .ifu_exu_valid_e(ifu_exu_valid_e), .ifu_exu_alu_valid_e(alu_valid),
      .ifu_exu_bru_valid_e(bru_valid), .ifu_exu_lsu_valid_e(lsu_valid),
      .ifu_exu_alu_a_e(alu_a), .ifu_exu_alu_b_e(alu_b), .ifu_exu_pc_e(pc),
      .ifu_exu_alu_op_e(alu_op), .ifu_exu_bru_op_e(bru_op), .ifu_exu_lsu_op_e(lsu_op),
      .ifu_exu_bru_offset_e(bru_offset), .ifu_exu_imm_shifted_e(imm),
      .ifu_exu_rf_target_e(rf_target), .ifu_exu_wen_e(wen),
      .ifu_exu_rs1_d(rs1), .ifu_exu_rs2_d(rs2),
      .exu_ifu_rs1_data_d(rs1_data), .exu_ifu_rs2_data_d(rs2_data),
      .exu_ifu_stall_req(stall_req), .exu_ifu_br_taken_e(br_taken), .exu_ifu_brpc_e(brpc),
      .data_req(data_req), .data_addr(data_addr), .data_wr(data_wr),
      .data_wstrb(data_wstrb), .data_wdata(data_wdata), .data_addr_ok(data_addr_ok),
      .data_rdata_m(data_rdata_m), .data_data_ok_m(data_data_ok_m)
   );

   always #10 clk = ~clk;

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      if (exp !== act) begin
         err_count++;
         $display("error %s: expected %h actual %h", name, exp, act);
      end
   endtask

   // read both ports at the current falling edge
   task automatic check_reg(input string name, input logic [4:0] idx);
      rs1 = idx;
      rs2 = idx;
      #1;
      check(name, reg_exp[idx], rs1_data);
      check(name, reg_exp[idx], rs2_data);
   endtask

   // unit 0 is alu, 1 branch, 2 load/store
   task automatic issue(input int unit, input logic [3:0] op, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] p, input logic [31:0] off,
                        input logic [4:0] rd, input logic we);
      @(negedge clk);
      ifu_exu_valid_e = 1'b1;
      alu_valid = (unit == 0);
      bru_valid = (unit == 1);
      lsu_valid = (unit == 2);
      alu_op = op;
      bru_op = op;
      lsu_op = op[2:0];
      alu_a = a;
      alu_b = b;
      pc = p;
      bru_offset = off;
      imm = off;
      rf_target = rd;
      wen = we;
      if (unit == 2) begin
         lsu_count++;
      end
      #1;
      if (unit == 1) begin
         check("br_taken", {31'd0, ref_taken(op, a, b)}, {31'd0, br_taken});
         check("brpc", (op == BRU_JIRL) ? a + off : p + off, brpc);
      end else begin
         check("br_taken idle", 32'd0, {31'd0, br_taken});
         check("brpc idle", 32'd0, brpc);
      end
      @(negedge clk);
      while (stall_seen) begin
         @(negedge clk);
      end
      ifu_exu_valid_e = 1'b0;
      alu_valid = 1'b0;
      bru_valid = 1'b0;
      lsu_valid = 1'b0;
      // two more edges until the result is in the register file
      repeat (2) @(posedge clk);
      @(negedge clk);
   endtask

   // memory responder and handshake monitor on the rising edge
   always @(posedge clk) begin
      if (!rst_n) begin
         load_pend <= 1'b0;
         data_cnt <= 2'd0;
         addr_wait <= 2'd0;
      end else begin
         stall_seen <= stall_req;
         exp_store = (lsu_op == LSU_STB) || (lsu_op == LSU_STW);
         exp_stall = ifu_exu_valid_e && lsu_valid &&
            !(exp_store ? data_addr_ok : data_data_ok_m);
         if (exp_stall !== stall_req) begin
            err_count++;
            $display("error stall_req: expected %h actual %h", exp_stall, stall_req);
         end
         if (data_req && data_addr_ok) begin
            req_count <= req_count + 1;
            check("data_addr", exp_addr, data_addr);
            check("data_wr", {31'd0, exp_store}, {31'd0, data_wr});
            if (data_wr) begin
               check("data_wstrb", {28'd0, exp_wstrb}, {28'd0, data_wstrb});
               check("data_wdata", exp_wdata, data_wdata);
               for (int k = 0; k < 4; k++) begin
                  if (data_wstrb[k]) begin
                     mem[data_addr[7:2]][k*8 +: 8] <= data_wdata[k*8 +: 8];
                  end
               end
            end else begin
               load_pend <= 1'b1;
               load_addr <= data_addr;
               data_cnt <= 2'($urandom % 3);
            end
            addr_wait <= 2'($urandom % 4);
         end else if (data_req && addr_wait != 0) begin
            addr_wait <= addr_wait - 2'd1;
         end
         if (data_data_ok_m) begin
            load_pend <= 1'b0;
         end else if (load_pend && data_cnt != 0) begin
            data_cnt <= data_cnt - 2'd1;
         end
      end
   end

   always @(negedge clk) begin
      data_addr_ok <= rst_n && addr_wait == 0;
      data_data_ok_m <= load_pend && data_cnt == 0;
      data_rdata_m <= mem[load_addr[7:2]];
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      logic [3:0]  op;
      logic [31:0] a, b, p, off, addr, base, word;
      logic [4:0]  rd;
      logic        lk;
      void'($urandom(22));
      rst_n = 1'b0;
      {ifu_exu_valid_e, alu_valid, bru_valid, lsu_valid, wen} = '0;
      {alu_a, alu_b, pc, bru_offset, imm} = '0;
      {alu_op, bru_op, lsu_op, rf_target, rs1, rs2} = '0;
      {data_addr_ok, data_data_ok_m, data_rdata_m, load_addr} = '0;
      {exp_addr, exp_wdata, exp_wstrb} = '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = fill_word(i);
         mem_exp[i] = fill_word(i);
      end
      for (int i = 0; i < 32; i++) begin
         reg_exp[i] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      @(negedge clk);
      check("reset data_req", 32'd0, {31'd0, data_req});
      check("reset stall_req", 32'd0, {31'd0, stall_req});
      check("reset br_taken", 32'd0, {31'd0, br_taken});
      for (int i = 0; i < 32; i++) begin
         @(negedge clk);
         check_reg("reset regs", 5'(i));
      end

      for (int i = 0; i < 150; i++) begin
         op = 4'($urandom % 12);
         a = $urandom;
         b = $urandom;
         rd = 5'(1 + $urandom % 31);
         reg_exp[rd] = ref_alu(op, a, b);
         issue(0, op, a, b, 0, 0, rd, 1'b1);
         check_reg("alu", rd);
      end

      for (int i = 0; i < 5; i++) begin
         issue(0, ALU_OR, $urandom, $urandom | 1, 0, 0, 5'd0, 1'b1);
         check_reg("r0", 5'd0);
      end

      for (int i = 0; i < 36; i++) begin
         op = 4'(i % 9);
         a = $urandom;
         b = ($urandom % 2) ? a : $urandom;
         p = $urandom & ~32'd3;
         off = (($urandom % 1024) * 4) - 32'd2048;
         rd = 5'(1 + $urandom % 31);
         lk = (op == BRU_BL) || (op == BRU_JIRL);
         if (lk) begin
            reg_exp[rd] = p + 32'd4;
         end
         issue(1, op, a, b, p, off, rd, lk);
         check_reg("branch link", rd);
      end

      for (int i = 0; i < 60; i++) begin
         op = ($urandom % 2) ? 4'(LSU_STB) : 4'(LSU_STW);
         addr = ($urandom % 64) * 4 + ((op == LSU_STB) ? $urandom % 4 : 0);
         base = $urandom;
         word = $urandom;
         exp_addr = addr;
         if (op == LSU_STW) begin
            exp_wstrb = 4'b1111;
            exp_wdata = word;
            mem_exp[addr[7:2]] = word;
         end else begin
            exp_wstrb = 4'b0001 << addr[1:0];
            exp_wdata = {4{word[7:0]}};
            mem_exp[addr[7:2]][addr[1:0]*8 +: 8] = word[7:0];
         end
         issue(2, op, base, word, 0, addr - base, 5'd0, 1'b0);
      end

      for (int i = 0; i < 60; i++) begin
         op = 4'(i % 3);
         addr = ($urandom % 64) * 4 + ((op == LSU_LDW) ? 0 : $urandom % 4);
         base = $urandom;
         rd = 5'(1 + $urandom % 31);
         exp_addr = addr;
         reg_exp[rd] = ref_load(op[2:0], mem_exp[addr[7:2]], addr[1:0]);
         issue(2, op, base, 0, 0, addr - base, rd, 1'b1);
         check_reg("load", rd);
      end

      if (req_count != lsu_count) begin
         err_count++;
         $display("%0d memory requests accepted for %0d loads and stores", req_count, lsu_count);
      end
      $display("checks %0d errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- source/cpu7_exu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu7_exu import exu_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     ifu_exu_valid_e,
   input  logic                     ifu_exu_alu_valid_e,
   input  logic                     ifu_exu_bru_valid_e,
   input  logic                     ifu_exu_lsu_valid_e,
   input  logic [GRLEN-1:0]         ifu_exu_alu_a_e,
   input  logic [GRLEN-1:0]         ifu_exu_alu_b_e,
   input  logic [GRLEN-1:0]         ifu_exu_pc_e,
   input  logic [ALU_OP_BITS-1:0]   ifu_exu_alu_op_e,
   input  logic [BRU_OP_BITS-1:0]   ifu_exu_bru_op_e,
   input  logic [LSU_OP_BITS-1:0]   ifu_exu_lsu_op_e,
   input  logic [GRLEN-1:0]         ifu_exu_bru_offset_e,
   input  logic [GRLEN-1:0]         ifu_exu_imm_shifted_e,
   input  logic [REG_ADDR_BITS-1:0] ifu_exu_rf_target_e,
   input  logic                     ifu_exu_wen_e,

   input  logic [REG_ADDR_BITS-1:0] ifu_exu_rs1_d,
   input  logic [REG_ADDR_BITS-1:0] ifu_exu_rs2_d,
   output logic [GRLEN-1:0]         exu_ifu_rs1_data_d,
   output logic [GRLEN-1:0]         exu_ifu_rs2_data_d,

   output logic                     exu_ifu_stall_req,
   output logic                     exu_ifu_br_taken_e,
   output logic [GRLEN-1:0]         exu_ifu_brpc_e,

   // data memory port
   output logic                     data_req,
   output logic [GRLEN-1:0]         data_addr,
   output logic                     data_wr,
   output logic [3:0]               data_wstrb,
   output logic [GRLEN-1:0]         data_wdata,
   input  logic                     data_addr_ok,
   input  logic [GRLEN-1:0]         data_rdata_m,
   input  logic                     data_data_ok_m
);

   logic [GRLEN-1:0]         ecl_alu_a_e;
   logic [GRLEN-1:0]         ecl_alu_b_e;
   logic [ALU_OP_BITS-1:0]   ecl_alu_op_e;
   logic [GRLEN-1:0]         alu_ecl_res_e;

   logic                     ecl_bru_valid_e;
   logic [BRU_OP_BITS-1:0]   ecl_bru_op_e;
   logic [GRLEN-1:0]         ecl_bru_a_e;
   logic [GRLEN-1:0]         ecl_bru_b_e;
   logic [GRLEN-1:0]         ecl_bru_pc_e;
   logic [GRLEN-1:0]         ecl_bru_offset_e;
   logic                     bru_ecl_taken_e;
   logic [GRLEN-1:0]         bru_ecl_target_e;
   logic [GRLEN-1:0]         bru_ecl_link_pc_e;

   logic                     ecl_lsu_valid_e;
   logic [LSU_OP_BITS-1:0]   ecl_lsu_op_e;
   logic [GRLEN-1:0]         ecl_lsu_base_e;
   logic [GRLEN-1:0]         ecl_lsu_offset_e;
   logic [GRLEN-1:0]         ecl_lsu_wdata_e;
   logic [REG_ADDR_BITS-1:0] ecl_lsu_rd_e;
   logic                     lsu_ecl_addr_done_e;
   logic                     lsu_ecl_finish_m;
   logic [GRLEN-1:0]         lsu_ecl_rdata_m;
   logic [REG_ADDR_BITS-1:0] lsu_ecl_rd_m;

   logic [REG_ADDR_BITS-1:0] ecl_irf_waddr_w;
   logic [GRLEN-1:0]         ecl_irf_wdata_w;
   logic                     ecl_irf_wen_w;

   exu_ecl ecl (
      .clk            (clk                  ),
      .rst_n          (rst_n                ),
      .ifu_exu_valid_e(ifu_exu_valid_e      ),
      .alu_valid      (ifu_exu_alu_valid_e  ),
      .bru_valid      (ifu_exu_bru_valid_e  ),
      .lsu_valid      (ifu_exu_lsu_valid_e  ),
      .alu_a          (ifu_exu_alu_a_e      ),
      .alu_b          (ifu_exu_alu_b_e      ),
      .alu_op         (ifu_exu_alu_op_e     ),
      .bru_op         (ifu_exu_bru_op_e     ),
      .lsu_op         (ifu_exu_lsu_op_e     ),
      .pc             (ifu_exu_pc_e         ),
      .bru_offset     (ifu_exu_bru_offset_e ),
      .lsu_imm        (ifu_exu_imm_shifted_e),
      .rf_target      (ifu_exu_rf_target_e  ),
      .wen            (ifu_exu_wen_e        ),
      .alu_res        (alu_ecl_res_e        ),
      .bru_taken      (bru_ecl_taken_e      ),
      .bru_target     (bru_ecl_target_e     ),
      .bru_link_pc    (bru_ecl_link_pc_e    ),
      .lsu_addr_done  (lsu_ecl_addr_done_e  ),
      .lsu_finish_m   (lsu_ecl_finish_m     ),
      .lsu_rdata_m    (lsu_ecl_rdata_m      ),
      .lsu_rd_m       (lsu_ecl_rd_m         ),
      .ecl_alu_a      (ecl_alu_a_e          ),
      .ecl_alu_b      (ecl_alu_b_e          ),
      .ecl_alu_op     (ecl_alu_op_e         ),
      .ecl_bru_valid  (ecl_bru_valid_e      ),
      .ecl_bru_op     (ecl_bru_op_e         ),
      .ecl_bru_a      (ecl_bru_a_e          ),
      .ecl_bru_b      (ecl_bru_b_e          ),
      .ecl_bru_pc     (ecl_bru_pc_e         ),
      .ecl_bru_offset (ecl_bru_offset_e     ),
      .ecl_lsu_valid  (ecl_lsu_valid_e      ),
      .ecl_lsu_op     (ecl_lsu_op_e         ),
      .ecl_lsu_base   (ecl_lsu_base_e       ),
      .ecl_lsu_offset (ecl_lsu_offset_e     ),
      .ecl_lsu_wdata  (ecl_lsu_wdata_e      ),
      .ecl_lsu_rd     (ecl_lsu_rd_e         ),
      .irf_waddr      (ecl_irf_waddr_w      ),
      .irf_wdata      (ecl_irf_wdata_w      ),
      .irf_wen        (ecl_irf_wen_w        ),
      .stall_req      (exu_ifu_stall_req    ),
      .br_taken       (exu_ifu_br_taken_e   ),
      .br_target      (exu_ifu_brpc_e       )
   );

   exu_alu alu (
      .a  (ecl_alu_a_e  ),
      .b  (ecl_alu_b_e  ),
      .op (ecl_alu_op_e ),
      .res(alu_ecl_res_e)
   );

   exu_bru bru (
      .valid  (ecl_bru_valid_e  ),
      .op     (ecl_bru_op_e     ),
      .a      (ecl_bru_a_e      ),
      .b      (ecl_bru_b_e      ),
      .pc     (ecl_bru_pc_e     ),
      .offset (ecl_bru_offset_e ),
      .taken  (bru_ecl_taken_e  ),
      .target (bru_ecl_target_e ),
      .link_pc(bru_ecl_link_pc_e)
   );

   exu_lsu lsu (
      .clk           (clk                ),
      .rst_n         (rst_n              ),
      .valid         (ecl_lsu_valid_e    ),
      .op            (ecl_lsu_op_e       ),
      .base          (ecl_lsu_base_e     ),
      .offset        (ecl_lsu_offset_e   ),
      .wdata         (ecl_lsu_wdata_e    ),
      .rd            (ecl_lsu_rd_e       ),
      .data_addr_ok  (data_addr_ok       ),
      .data_data_ok_m(data_data_ok_m     ),
      .data_rdata_m  (data_rdata_m       ),
      .data_req      (data_req           ),
      .data_addr     (data_addr          ),
      .data_wr       (data_wr            ),
      .data_wstrb    (data_wstrb         ),
      .data_wdata    (data_wdata         ),
      .addr_done     (lsu_ecl_addr_done_e),
      .finish_m      (lsu_ecl_finish_m   ),
      .rdata_m       (lsu_ecl_rdata_m    ),
      .rd_m          (lsu_ecl_rd_m       )
   );

   exu_regfile registers (
      .clk   (clk               ),
      .rst_n (rst_n             ),
      .raddr0(ifu_exu_rs1_d     ),
      .raddr1(ifu_exu_rs2_d     ),
      .waddr (ecl_irf_waddr_w   ),
      .wdata (ecl_irf_wdata_w   ),
      .wen   (ecl_irf_wen_w     ),
      .rdata0(exu_ifu_rs1_data_d),
      .rdata1(exu_ifu_rs2_data_d)
   );

endmodule

`default_nettype wire

//--- source/exu_ecl.sv
`timescale 1ns/1ns
`default_nettype none

module exu_ecl import exu_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     ifu_exu_valid_e,
   input  logic                     alu_valid,
   input  logic                     bru_valid,
   input  logic                     lsu_valid,
   input  logic [GRLEN-1:0]         alu_a,
   input  logic [GRLEN-1:0]         alu_b,
   input  logic [ALU_OP_BITS-1:0]   alu_op,
   input  logic [BRU_OP_BITS-1:0]   bru_op,
   input  logic [LSU_OP_BITS-1:0]   lsu_op,
   input  logic [GRLEN-1:0]         pc,
   input  logic [GRLEN-1:0]         bru_offset,
   input  logic [GRLEN-1:0]         lsu_imm,
   input  logic [REG_ADDR_BITS-1:0] rf_target,
   input  logic                     wen,

   input  logic [GRLEN-1:0]         alu_res,
   input  logic                     bru_taken,
   input  logic [GRLEN-1:0]         bru_target,
   input  logic [GRLEN-1:0]         bru_link_pc,
   input  logic                     lsu_addr_done,
   input  logic                     lsu_finish_m,
   input  logic [GRLEN-1:0]         lsu_rdata_m,
   input  logic [REG_ADDR_BITS-1:0] lsu_rd_m,

   output logic [GRLEN-1:0]         ecl_alu_a,
   output logic [GRLEN-1:0]         ecl_alu_b,
   output logic [ALU_OP_BITS-1:0]   ecl_alu_op,
   output logic                     ecl_bru_valid,
   output logic [BRU_OP_BITS-1:0]   ecl_bru_op,
   output logic [GRLEN-1:0]         ecl_bru_a,
   output logic [GRLEN-1:0]         ecl_bru_b,
   output logic [GRLEN-1:0]         ecl_bru_pc,
   output logic [GRLEN-1:0]         ecl_bru_offset,
   output logic                     ecl_lsu_valid,
   output logic [LSU_OP_BITS-1:0]   ecl_lsu_op,
   output logic [GRLEN-1:0]         ecl_lsu_base,
   output logic [GRLEN-1:0]         ecl_lsu_offset,
   output logic [GRLEN-1:0]         ecl_lsu_wdata,
   output logic [REG_ADDR_BITS-1:0] ecl_lsu_rd,

   output logic [REG_ADDR_BITS-1:0] irf_waddr,
   output logic [GRLEN-1:0]         irf_wdata,
   output logic                     irf_wen,

   output logic                     stall_req,
   output logic                     br_taken,
   output logic [GRLEN-1:0]         br_target
);

   logic                     accept_e;
   logic                     store_e;
   logic                     link_e;
   logic                     m_wen;
   logic [REG_ADDR_BITS-1:0] m_rd;
   logic [GRLEN-1:0]         m_data;
   logic                     w_wen;
   logic [REG_ADDR_BITS-1:0] w_rd;
   logic [GRLEN-1:0]         w_data;

   assign ecl_alu_a      = alu_a;
   assign ecl_alu_b      = alu_b;
   assign ecl_alu_op     = alu_op;

   assign ecl_bru_valid  = ifu_exu_valid_e & bru_valid;
   assign ecl_bru_op     = bru_op;
   assign ecl_bru_a      = alu_a;
   assign ecl_bru_b      = alu_b;
   assign ecl_bru_pc     = pc;
   assign ecl_bru_offset = bru_offset;

   // rs2 value carries the store data
   assign ecl_lsu_valid  = ifu_exu_valid_e & lsu_valid;
   assign ecl_lsu_op     = lsu_op;
   assign ecl_lsu_base   = alu_a;
   assign ecl_lsu_offset = lsu_imm;
   assign ecl_lsu_wdata  = alu_b;
   assign ecl_lsu_rd     = rf_target;

   assign br_taken  = bru_taken;
   assign br_target = bru_target;

   assign store_e = (lsu_op == LSU_STB) || (lsu_op == LSU_STW);
   assign link_e  = (bru_op == BRU_BL) || (bru_op == BRU_JIRL);

   // stores are done at address accept, loads at data_ok
   assign stall_req = ecl_lsu_valid & ~lsu_finish_m & ~(lsu_addr_done & store_e);
   assign accept_e  = ifu_exu_valid_e & ~stall_req;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         m_wen <= 1'b0;
         w_wen <= 1'b0;
      end else begin
         m_wen <= accept_e & wen & (alu_valid | (bru_valid & link_e));
         // load result skips M and lands straight in W
         w_wen <= lsu_finish_m ? wen : m_wen;
      end
   end

   always_ff @(posedge clk) begin
      m_rd   <= rf_target;
      m_data <= alu_valid ? alu_res : bru_link_pc;
      if (lsu_finish_m) begin
         w_rd   <= lsu_rd_m;
         w_data <= lsu_rdata_m;
      end else begin
         w_rd   <= m_rd;
         w_data <= m_data;
      end
   end

   assign irf_waddr = w_rd;
   assign irf_wdata = w_data;
   assign irf_wen   = w_wen;

   unit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
      ifu_exu_valid_e |-> $onehot0({alu_valid, bru_valid, lsu_valid}));

   // M is always drained by the time a load returns
   load_m_free_a: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_finish_m |-> !m_wen);

endmodule

`default_nettype wire

//--- source/exu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module exu_regfile import exu_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [REG_ADDR_BITS-1:0] raddr0,
   input  logic [REG_ADDR_BITS-1:0] raddr1,
   input  logic [REG_ADDR_BITS-1:0] waddr,
   input  logic [GRLEN-1:0]         wdata,
   input  logic                     wen,
   output logic [GRLEN-1:0]         rdata0,
   output logic [GRLEN-1:0]         rdata1
);

   logic [GRLEN-1:0] regs [2**REG_ADDR_BITS];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**REG_ADDR_BITS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         // r0 is hardwired zero
         regs[waddr] <= wdata;
      end
   end

   assign rdata0 = regs[raddr0];
   assign rdata1 = regs[raddr1];

   r0_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
      (raddr0 == '0 |-> rdata0 == '0) and (raddr1 == '0 |-> rdata1 == '0));

endmodule

`default_nettype wire

//--- source/exu_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_lsu import exu_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,

   input  logic                     valid,
   input  logic [LSU_OP_BITS-1:0]   op,
   input  logic [GRLEN-1:0]         base,
   input  logic [GRLEN-1:0]         offset,
   input  logic [GRLEN-1:0]         wdata,
   input  logic [REG_ADDR_BITS-1:0] rd,

   input  logic                     data_addr_ok,
   input  logic                     data_data_ok_m,
   input  logic [GRLEN-1:0]         data_rdata_m,
   output logic                     data_req,
   output logic [GRLEN-1:0]         data_addr,
   output logic                     data_wr,
   output logic [3:0]               data_wstrb,
   output logic [GRLEN-1:0]         data_wdata,

   output logic                     addr_done,
   output logic                     finish_m,
   output logic [GRLEN-1:0]         rdata_m,
   output logic [REG_ADDR_BITS-1:0] rd_m
);

   logic                     is_store;
   logic                     wait_q;
   logic [1:0]               lo_q;
   logic [LSU_OP_BITS-1:0]   op_q;
   logic [REG_ADDR_BITS-1:0] rd_q;
   logic [7:0]               byte_m;

   assign is_store  = (op == LSU_STB) || (op == LSU_STW);
   assign data_addr = base + offset;

   // no new request while a load is still out
   assign data_req  = valid & ~wait_q;
   assign data_wr   = data_req & is_store;
   assign addr_done = data_req & data_addr_ok;

   always_comb begin
      data_wstrb = 4'b0000;
      data_wdata = wdata;
      if (data_wr && op == LSU_STW) begin
         data_wstrb = 4'b1111;
      end else if (data_wr) begin
         // byte lane picked by the low address bits
         data_wstrb = 4'b0001 << data_addr[1:0];
         data_wdata = {4{wdata[7:0]}};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wait_q <= 1'b0;
      end else if (addr_done && !is_store) begin
         wait_q <= 1'b1;
      end else if (data_data_ok_m) begin
         wait_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (addr_done) begin
         lo_q <= data_addr[1:0];
         op_q <= op;
         rd_q <= rd;
      end
   end

   assign finish_m = wait_q & data_data_ok_m;
   assign rd_m     = rd_q;
   assign byte_m   = data_rdata_m[{lo_q, 3'b000} +: 8];

   always_comb begin
      case (op_q)
         LSU_LDB:  rdata_m = {{(GRLEN-8){byte_m[7]}}, byte_m};
         LSU_LDBU: rdata_m = {{(GRLEN-8){1'b0}}, byte_m};
         LSU_LDW:  rdata_m = data_rdata_m;
         default:  rdata_m = data_rdata_m;
      endcase
   end

   // relies on the fetch side holding its inputs during the stall
   req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      data_req && !data_addr_ok |=> data_req && $stable(data_addr));

   data_ok_load_a: assert property (@(posedge clk) disable iff (!rst_n)
      data_data_ok_m |-> wait_q);

endmodule

`default_nettype wire

//--- source/exu_bru.sv
`timescale 1ns/1ns
`default_nettype none

module exu_bru import exu_pkg::*; (
   input  logic                   valid,
   input  logic [BRU_OP_BITS-1:0] op,
   input  logic [GRLEN-1:0]       a,
   input  logic [GRLEN-1:0]       b,
   input  logic [GRLEN-1:0]       pc,
   input  logic [GRLEN-1:0]       offset,
   output logic                   taken,
   output logic [GRLEN-1:0]       target,
   output logic [GRLEN-1:0]       link_pc
);

   logic             cond;
   logic [GRLEN-1:0] base;

   always_comb begin
      case (op)
         BRU_BEQ:  cond = (a == b);
         BRU_BNE:  cond = (a != b);
         BRU_BLT:  cond = ($signed(a) < $signed(b));
         BRU_BGE:  cond = ($signed(a) >= $signed(b));
         BRU_BLTU: cond = (a < b);
         BRU_BGEU: cond = (a >= b);
         BRU_B,
         BRU_BL,
         BRU_JIRL: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   // jirl jumps relative to rj, everything else to pc
   assign base = (op == BRU_JIRL) ? a : pc;

   assign taken   = valid & cond;
   assign target  = valid ? base + offset : '0;
   assign link_pc = pc + 32'd4;

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu import exu_pkg::*; (
   input  logic [GRLEN-1:0]       a,
   input  logic [GRLEN-1:0]       b,
   input  logic [ALU_OP_BITS-1:0] op,
   output logic [GRLEN-1:0]       res
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         ALU_ADD: begin
            res = a + b;
         end
         ALU_SUB: begin
            res = a - b;
         end
         ALU_AND: begin
            res = a & b;
         end
         ALU_OR: begin
            res = a | b;
         end
         ALU_XOR: begin
            res = a ^ b;
         end
         ALU_NOR: begin
            res = ~(a | b);
         end
         ALU_SLT: begin
            res = {{(GRLEN-1){1'b0}}, $signed(a) < $signed(b)};
         end
         ALU_SLTU: begin
            res = {{(GRLEN-1){1'b0}}, a < b};
         end
         ALU_SLL: begin
            res = a << shamt;
         end
         ALU_SRL: begin
            res = a >> shamt;
         end
         ALU_SRA: begin
            res = $signed(a) >>> shamt;
         end
         ALU_LUI: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/exu_pkg.sv
`default_nettype none

package exu_pkg;

   localparam int GRLEN         = 32;
   localparam int REG_ADDR_BITS = 5;

   localparam int ALU_OP_BITS = 4;

   localparam logic [ALU_OP_BITS-1:0] ALU_ADD  = 4'd0;
   localparam logic [ALU_OP_BITS-1:0] ALU_SUB  = 4'd1;
   localparam logic [ALU_OP_BITS-1:0] ALU_AND  = 4'd2;
   localparam logic [ALU_OP_BITS-1:0] ALU_OR   = 4'd3;
   localparam logic [ALU_OP_BITS-1:0] ALU_XOR  = 4'd4;
   localparam logic [ALU_OP_BITS-1:0] ALU_NOR  = 4'd5;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLT  = 4'd6;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLTU = 4'd7;
   localparam logic [ALU_OP_BITS-1:0] ALU_SLL  = 4'd8;
   localparam logic [ALU_OP_BITS-1:0] ALU_SRL  = 4'd9;
   localparam logic [ALU_OP_BITS-1:0] ALU_SRA  = 4'd10;
   // lui just passes b through
   localparam logic [ALU_OP_BITS-1:0] ALU_LUI  = 4'd11;

   localparam int BRU_OP_BITS = 4;

   localparam logic [BRU_OP_BITS-1:0] BRU_BEQ  = 4'd0;
   localparam logic [BRU_OP_BITS-1:0] BRU_BNE  = 4'd1;
   localparam logic [BRU_OP_BITS-1:0] BRU_BLT  = 4'd2;
   localparam logic [BRU_OP_BITS-1:0] BRU_BGE  = 4'd3;
   localparam logic [BRU_OP_BITS-1:0] BRU_BLTU = 4'd4;
   localparam logic [BRU_OP_BITS-1:0] BRU_BGEU = 4'd5;
   localparam logic [BRU_OP_BITS-1:0] BRU_B    = 4'd6;
   localparam logic [BRU_OP_BITS-1:0] BRU_BL   = 4'd7;
   localparam logic [BRU_OP_BITS-1:0] BRU_JIRL = 4'd8;

   localparam int LSU_OP_BITS = 3;

   localparam logic [LSU_OP_BITS-1:0] LSU_LDB  = 3'd0;
   localparam logic [LSU_OP_BITS-1:0] LSU_LDBU = 3'd1;
   localparam logic [LSU_OP_BITS-1:0] LSU_LDW  = 3'd2;
   localparam logic [LSU_OP_BITS-1:0] LSU_STB  = 3'd3;
   localparam logic [LSU_OP_BITS-1:0] LSU_STW  = 3'd4;

endpackage

`default_nettype wire
